//--- logic/uart_rx_pkg.sv
// ************************************************
// Widths, bus and status structs, register map
// and reset constants of the UART receiver
// ************************************************
`default_nettype none

package uart_rx_pkg;

  // ************************************************
  // Field widths
  // ************************************************
  // Clock cycles per serial bit
  typedef logic [13:0] bit_period_t;
  // Data bits per packet, legal range 5 to 8
  typedef logic [3:0]  data_size_t;
  typedef logic [7:0]  rx_byte_t;
  typedef logic [2:0]  apb_addr_t;
  typedef logic [7:0]  apb_data_t;

  // ************************************************
  // Bus and status bundles
  // ************************************************
  // Request side of the APB slave port
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  // Response side, combinational in the access cycle
  typedef struct packed {
    apb_data_t prdata;
    logic      pslverr;
  } apb_rsp_t;

  // Receiver configuration held by the register block
  typedef struct packed {
    bit_period_t bit_period;
    data_size_t  data_size;
  } rx_cfg_t;

  // Receive buffer contents and flags
  typedef struct packed {
    rx_byte_t rx_data;
    logic     data_ready;
    logic     framing_error;
    logic     overrun_error;
  } rx_status_t;

  // Register map
  localparam apb_addr_t ADDR_DATA_SR  = 3'd0;
  localparam apb_addr_t ADDR_ERROR_SR = 3'd1;
  localparam apb_addr_t ADDR_BIT_CR0  = 3'd2;
  localparam apb_addr_t ADDR_BIT_CR1  = 3'd3;
  localparam apb_addr_t ADDR_DATA_CR  = 3'd4;
  localparam apb_addr_t ADDR_RX_DATA  = 3'd6;

  // Configuration after reset
  localparam bit_period_t RESET_BIT_PERIOD = 14'd10;
  localparam data_size_t  RESET_DATA_SIZE  = 4'd8;

  // Accepted data size window
  localparam data_size_t MIN_DATA_SIZE = 4'd5;
  localparam data_size_t MAX_DATA_SIZE = 4'd8;

endpackage

`default_nettype wire

//--- logic/apb_uart_regs.sv
// ************************************************
// APB slave with bit period and data size registers,
// status readback and the data_read pulse
// ************************************************
`timescale 1ns/10ps
`default_nettype none

module apb_uart_regs
  import uart_rx_pkg::*;
(
  input  logic       tb_clk,
  input  logic       reset,
  input  apb_req_t   apb_req,
  output apb_rsp_t   apb_rsp,
  input  rx_status_t status,
  output rx_cfg_t    cfg,
  output logic       data_read
);

  logic      access;
  logic      wr_access;
  logic      rd_access;
  logic      size_ok;
  logic      addr_err;
  logic      wr_err;
  apb_data_t rd_data;

  // Access phase of a transfer, no wait states
  assign access    = apb_req.psel && apb_req.penable;
  assign wr_access = access && apb_req.pwrite;
  assign rd_access = access && !apb_req.pwrite;

  // Data size must stay inside what the receiver frames
  assign size_ok = (apb_req.pwdata >= MIN_DATA_SIZE) &&
                   (apb_req.pwdata <= MAX_DATA_SIZE);

  // ************************************************
  // Address decode and read mux
  // ************************************************
  always_comb
  begin
    rd_data  = '0;
    addr_err = 1'b0;
    wr_err   = 1'b0;
    case (apb_req.paddr)
      ADDR_DATA_SR:
      begin
        rd_data = {7'd0, status.data_ready};
        wr_err  = 1'b1;
      end
      ADDR_ERROR_SR:
      begin
        // Overrun in bit 1, framing in bit 0
        rd_data = {6'd0, status.overrun_error, status.framing_error};
        wr_err  = 1'b1;
      end
      ADDR_BIT_CR0:
        rd_data = cfg.bit_period[7:0];
      ADDR_BIT_CR1:
        rd_data = {2'd0, cfg.bit_period[13:8]};
      ADDR_DATA_CR:
      begin
        rd_data = {4'd0, cfg.data_size};
        wr_err  = !size_ok;
      end
      ADDR_RX_DATA:
      begin
        rd_data = status.rx_data;
        wr_err  = 1'b1;
      end
      // Addresses 5 and 7 are holes in the map
      default:
        addr_err = 1'b1;
    endcase
  end

  assign apb_rsp.prdata  = rd_data;
  assign apb_rsp.pslverr = access && (addr_err || (apb_req.pwrite && wr_err));

  // ************************************************
  // Configuration registers
  // ************************************************
  always_ff @(posedge tb_clk)
  begin
    if (reset)
    begin
      cfg.bit_period <= RESET_BIT_PERIOD;
      cfg.data_size  <= RESET_DATA_SIZE;
      data_read      <= 1'b0;
    end
    else
    begin
      // One pulse in the cycle after a data register read
      data_read <= rd_access && (apb_req.paddr == ADDR_RX_DATA);
      if (wr_access)
      begin
        case (apb_req.paddr)
          ADDR_BIT_CR0:
            cfg.bit_period[7:0] <= apb_req.pwdata;
          ADDR_BIT_CR1:
            cfg.bit_period[13:8] <= apb_req.pwdata[5:0];
          ADDR_DATA_CR:
          begin
            // Illegal sizes are dropped along with the error
            if (size_ok)
              cfg.data_size <= apb_req.pwdata[3:0];
          end
          default:
            cfg <= cfg;
        endcase
      end
    end
  end

  // Master opens every access phase with a setup phase
  a_apb_setup_access: assert property (@(posedge tb_clk) disable iff (reset)
    apb_req.penable |-> apb_req.psel && $past(apb_req.psel))
  else
    $error("APB access phase without psel or setup phase");

endmodule

`default_nettype wire

//--- logic/uart_rx_timer.sv
// ************************************************
// Bit period down-counter giving mid-bit sample ticks
// ************************************************
`timescale 1ns/10ps
`default_nettype none

module uart_rx_timer
  import uart_rx_pkg::*;
(
  input  logic        tb_clk,
  input  logic        reset,
  input  bit_period_t bit_period,
  input  logic        timer_start,
  input  logic        timer_run,
  output logic        sample_tick
);

  bit_period_t count;
  bit_period_t half_load;
  logic        active;

  // First tick lands half a period after the start edge
  assign half_load = (bit_period >> 1) - 14'd1;

  // Tick on terminal count while armed
  assign sample_tick = active && (count == '0);

  always_ff @(posedge tb_clk)
  begin
    if (reset)
    begin
      count  <= '0;
      active <= 1'b0;
    end
    else if (timer_start)
    begin
      count  <= half_load;
      active <= 1'b1;
    end
    else
    begin
      // Disarm once the controller leaves the packet
      active <= active && timer_run;
      if (active)
      begin
        if (count == '0)
          count <= bit_period - 14'd1;
        else
          count <= count - 14'd1;
      end
    end
  end

  // Controller and timer agree on when a packet is open
  a_tick_in_packet: assert property (@(posedge tb_clk) disable iff (reset)
    sample_tick |-> timer_run)
  else
    $error("sample tick outside a packet");

endmodule

`default_nettype wire

//--- logic/uart_rx_ctrl.sv
// ************************************************
// Input synchronizer, start edge detect and the
// packet FSM of the receiver
// ************************************************
`timescale 1ns/10ps
`default_nettype none

module uart_rx_ctrl
  import uart_rx_pkg::*;
#(
  parameter int SYNC_STAGES = 2
)
(
  input  logic       tb_clk,
  input  logic       reset,
  input  logic       serial_in,
  input  data_size_t data_size,
  input  logic       sample_tick,
  output logic       timer_start,
  output logic       timer_run,
  output logic       serial_sync,
  output logic       shift_en,
  output logic       packet_done,
  output logic       stop_bit
);

  typedef enum logic [2:0] {IDLE, START, DATA, STOP, LOAD} rx_state_t;

  rx_state_t              state;
  rx_state_t              next_state;
  logic [SYNC_STAGES-1:0] sync_q;
  logic                   serial_prev;
  logic                   start_edge;
  logic                   last_bit;
  data_size_t             bit_cnt;

  // ************************************************
  // Synchronizer and edge detect
  // ************************************************
  // Line idles high, so the chain resets to ones
  always_ff @(posedge tb_clk)
  begin
    if (reset)
    begin
      sync_q      <= '1;
      serial_prev <= 1'b1;
    end
    else
    begin
      sync_q      <= {sync_q[SYNC_STAGES-2:0], serial_in};
      serial_prev <= serial_sync;
    end
  end

  assign serial_sync = sync_q[SYNC_STAGES-1];
  assign start_edge  = serial_prev && !serial_sync;

  // ************************************************
  // Packet FSM
  // ************************************************
  assign last_bit = (bit_cnt + 4'd1) >= data_size;

  always_comb
  begin
    next_state = state;
    case (state)
      IDLE:
        if (start_edge)
          next_state = START;
      // High at mid start bit means a glitch
      START:
        if (sample_tick)
          next_state = serial_sync ? IDLE : DATA;
      DATA:
        if (sample_tick && last_bit)
          next_state = STOP;
      STOP:
        if (sample_tick)
          next_state = LOAD;
      LOAD:
        next_state = IDLE;
      default:
        next_state = IDLE;
    endcase
  end

  always_ff @(posedge tb_clk)
  begin
    if (reset)
    begin
      state   <= IDLE;
      bit_cnt <= '0;
    end
    else
    begin
      state <= next_state;
      // Count data samples taken so far
      if (state == START)
        bit_cnt <= '0;
      else if (shift_en)
        bit_cnt <= bit_cnt + 4'd1;
    end
  end

  // Stop sample, qualified later by packet_done
  always_ff @(posedge tb_clk)
  begin
    if ((state == STOP) && sample_tick)
      stop_bit <= serial_sync;
  end

  assign timer_start = (state == IDLE) && start_edge;
  assign timer_run   = (state == START) || (state == DATA) || (state == STOP);
  assign shift_en    = (state == DATA) && sample_tick;
  assign packet_done = (state == LOAD);

  // Buffer loads exactly once per packet
  a_done_one_cycle: assert property (@(posedge tb_clk) disable iff (reset)
    packet_done |=> !packet_done)
  else
    $error("packet_done held longer than one cycle");

endmodule

`default_nettype wire

//--- logic/uart_rx_shifter.sv
// ************************************************
// Serial to parallel shifter, right aligned output
// ************************************************
`timescale 1ns/10ps
`default_nettype none

module uart_rx_shifter
  import uart_rx_pkg::*;
(
  input  logic       tb_clk,
  input  logic       reset,
  input  logic       serial_sync,
  input  logic       shift_en,
  input  data_size_t data_size,
  input  logic       packet_done,
  output rx_byte_t   rx_word
);

  rx_byte_t   shift_q;
  data_size_t align;

  // LSB arrives first, so bits enter at the top
  // Cleared after each packet, buffer samples on the same edge
  always_ff @(posedge tb_clk)
  begin
    if (reset || packet_done)
      shift_q <= '0;
    else if (shift_en)
      shift_q <= {serial_sync, shift_q[7:1]};
  end

  // Short packets sit in the top bits
  assign align = 4'd8 - data_size;

  // Logical shift fills zeros above the top data bit
  assign rx_word = shift_q >> align;

endmodule

`default_nettype wire

//--- logic/uart_rx_buffer.sv
// ************************************************
// One byte receive buffer with ready, framing and
// overrun flags
// ************************************************
`timescale 1ns/10ps
`default_nettype none

module uart_rx_buffer
  import uart_rx_pkg::*;
(
  input  logic       tb_clk,
  input  logic       reset,
  input  logic       packet_done,
  input  logic       stop_bit,
  input  rx_byte_t   rx_word,
  input  logic       data_read,
  output rx_status_t status
);

  always_ff @(posedge tb_clk)
  begin
    if (reset)
    begin
      status.rx_data       <= '1;
      status.data_ready    <= 1'b0;
      status.framing_error <= 1'b0;
      status.overrun_error <= 1'b0;
    end
    else
    begin
      // Software consumed the byte
      if (data_read)
      begin
        status.data_ready    <= 1'b0;
        status.overrun_error <= 1'b0;
      end
      if (packet_done)
      begin
        // Every packet refreshes the framing flag
        status.framing_error <= !stop_bit;
        if (stop_bit)
        begin
          // No back pressure so the new byte always wins
          status.rx_data    <= rx_word;
          status.data_ready <= 1'b1;
          // Unread byte is lost unless read on this same edge
          if (status.data_ready && !data_read)
            status.overrun_error <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/apb_uart_rx.sv
// ************************************************
// Top of the APB programmable UART receiver
// ************************************************
`timescale 1ns/10ps
`default_nettype none

module apb_uart_rx
  import uart_rx_pkg::*;
#(
  parameter int SYNC_STAGES = 2
)
(
  input  logic     tb_clk,
  input  logic     reset,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp,
  input  logic     serial_in
);

  // Register block to receive chain
  rx_cfg_t    cfg;
  rx_status_t status;
  logic       data_read;
  // Controller and timer handshake
  logic       timer_start;
  logic       timer_run;
  logic       sample_tick;
  // Datapath strobes
  logic       serial_sync;
  logic       shift_en;
  logic       packet_done;
  logic       stop_bit;
  rx_byte_t   rx_word;

  // ************************************************
  // APB side
  // ************************************************
  apb_uart_regs regs_inst (
    .tb_clk    (tb_clk),
    .reset     (reset),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .status    (status),
    .cfg       (cfg),
    .data_read (data_read)
  );

  // ************************************************
  // Receive chain
  // ************************************************
  uart_rx_ctrl #(
    .SYNC_STAGES (SYNC_STAGES)
  ) ctrl_inst (
    .tb_clk      (tb_clk),
    .reset       (reset),
    .serial_in   (serial_in),
    .data_size   (cfg.data_size),
    .sample_tick (sample_tick),
    .timer_start (timer_start),
    .timer_run   (timer_run),
    .serial_sync (serial_sync),
    .shift_en    (shift_en),
    .packet_done (packet_done),
    .stop_bit    (stop_bit)
  );

  uart_rx_timer timer_inst (
    .tb_clk      (tb_clk),
    .reset       (reset),
    .bit_period  (cfg.bit_period),
    .timer_start (timer_start),
    .timer_run   (timer_run),
    .sample_tick (sample_tick)
  );

  uart_rx_shifter shifter_inst (
    .tb_clk      (tb_clk),
    .reset       (reset),
    .serial_sync (serial_sync),
    .shift_en    (shift_en),
    .data_size   (cfg.data_size),
    .packet_done (packet_done),
    .rx_word     (rx_word)
  );

  uart_rx_buffer buffer_inst (
    .tb_clk      (tb_clk),
    .reset       (reset),
    .packet_done (packet_done),
    .stop_bit    (stop_bit),
    .rx_word     (rx_word),
    .data_read   (data_read),
    .status      (status)
  );

endmodule

`default_nettype wire

//--- testbench/tb_uart_tasks.svh
// ************************************************
// APB transfers, serial packet driver and typed
// compare tasks of the receiver testbench
// ************************************************
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

// ************************************************
// Compare tasks
// ************************************************
// First wrong value ends the run
task automatic report_mismatch(input string msg);
  $display("MISMATCH at %0d ns: %s", $time, msg);
  $display("=== FAIL ===");
  $fatal(1, "Run stopped at the first wrong value");
endtask

task automatic check_byte(input rx_byte_t got, input rx_byte_t exp, input string what);
  if (got !== exp)
    report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
endtask

task automatic check_cfg(input bit_period_t got_p, input data_size_t got_s,
                         input bit_period_t exp_p, input data_size_t exp_s);
  if ((got_p !== exp_p) || (got_s !== exp_s))
    report_mismatch($sformatf("config got period %0d size %0d expected period %0d size %0d",
                              got_p, got_s, exp_p, exp_s));
endtask

// Order is ready, framing, overrun
task automatic check_flags(input logic [2:0] got, input logic [2:0] exp, input string what);
  if (got !== exp)
    report_mismatch($sformatf("%s got %b expected %b", what, got, exp));
endtask

task automatic check_err(input logic got, input logic exp, input string what);
  if (got !== exp)
    report_mismatch($sformatf("%s pslverr got %b expected %b", what, got, exp));
endtask

// ************************************************
// APB master
// ************************************************
// Setup then access, response sampled mid access cycle
task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata, output logic err);
  @(negedge tb_clk);
  apb_req.psel    = 1'b1;
  apb_req.penable = 1'b0;
  apb_req.pwrite  = 1'b1;
  apb_req.paddr   = addr;
  apb_req.pwdata  = wdata;
  @(negedge tb_clk);
  apb_req.penable = 1'b1;
  #1;
  err = apb_rsp.pslverr;
  @(negedge tb_clk);
  apb_req = '0;
endtask

task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata, output logic err);
  @(negedge tb_clk);
  apb_req.psel    = 1'b1;
  apb_req.penable = 1'b0;
  apb_req.pwrite  = 1'b0;
  apb_req.paddr   = addr;
  apb_req.pwdata  = '0;
  @(negedge tb_clk);
  apb_req.penable = 1'b1;
  #1;
  rdata = apb_rsp.prdata;
  err   = apb_rsp.pslverr;
  @(negedge tb_clk);
  apb_req = '0;
endtask

// Legal transfers, pslverr must stay low
task automatic write_ok(input apb_addr_t addr, input apb_data_t wdata);
  logic err;
  apb_write(addr, wdata, err);
  check_err(err, 1'b0, "legal write");
endtask

task automatic read_ok(input apb_addr_t addr, output apb_data_t rdata);
  logic err;
  apb_read(addr, rdata, err);
  check_err(err, 1'b0, "legal read");
endtask

task automatic write_period(input bit_period_t period);
  write_ok(ADDR_BIT_CR0, period[7:0]);
  write_ok(ADDR_BIT_CR1, {2'd0, period[13:8]});
endtask

task automatic read_cfg(output bit_period_t period, output data_size_t size);
  apb_data_t lo;
  apb_data_t hi;
  apb_data_t sz;
  read_ok(ADDR_BIT_CR0, lo);
  read_ok(ADDR_BIT_CR1, hi);
  read_ok(ADDR_DATA_CR, sz);
  period = {hi[5:0], lo};
  size   = sz[3:0];
endtask

task automatic read_flags(output logic [2:0] flags);
  apb_data_t data_sr;
  apb_data_t error_sr;
  read_ok(ADDR_DATA_SR, data_sr);
  read_ok(ADDR_ERROR_SR, error_sr);
  flags = {data_sr[0], error_sr[0], error_sr[1]};
endtask

// ************************************************
// Serial line driver
// ************************************************
// LSB first, then two idle bit periods on the line
task automatic send_packet(input rx_byte_t data, input data_size_t size, input logic stop_val);
  @(negedge tb_clk);
  serial_in = 1'b0;
  repeat (TEST_PERIOD) @(negedge tb_clk);
  for (int i = 0; i < size; i++)
  begin
    serial_in = data[i];
    repeat (TEST_PERIOD) @(negedge tb_clk);
  end
  serial_in = stop_val;
  repeat (TEST_PERIOD) @(negedge tb_clk);
  serial_in = 1'b1;
  repeat (2 * TEST_PERIOD) @(negedge tb_clk);
endtask

`endif

//--- testbench/tb_apb_uart_rx.sv
// ************************************************
// Testbench of the APB UART receiver with clock, reset,
// DUT, reference model, test sequence and timeout
// ************************************************
`timescale 1ns/10ps
`default_nettype none

module tb_apb_uart_rx
  import uart_rx_pkg::*;
();

  // ************************************************
  // Run parameters
  // ************************************************
  localparam int          CLK_HALF     = 2;
  localparam int          RESET_CYCLES = 16;
  // Bit period used for all packets
  localparam bit_period_t TEST_PERIOD  = 14'd16;
  localparam int          NUM_PACKETS  = 6;
  // Start, data, stop and the two idle bits after each packet
  localparam int          PKT_CYCLES   = (MAX_DATA_SIZE + 4) * TEST_PERIOD;
  // Setup, access and idle cycles of all transfers rounded up
  localparam int          REG_CYCLES   = 64 * 5;
  localparam int          TIMEOUT_CYCLES =
    2 * (NUM_PACKETS * PKT_CYCLES + REG_CYCLES + RESET_CYCLES);

  logic        tb_clk;
  logic        reset;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic        serial_in;
  integer      seed;
  int          cycle_count;
  rx_byte_t    data_a;
  rx_byte_t    data_b;
  rx_byte_t    prev_byte;
  data_size_t  test_size;
  apb_data_t   rd_val;
  bit_period_t got_period;
  data_size_t  got_size;
  logic [2:0]  got_flags;
  logic        got_err;

  apb_uart_rx #(
    .SYNC_STAGES (2)
  ) apb_uart_rx_inst (
    .tb_clk    (tb_clk),
    .reset     (reset),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .serial_in (serial_in)
  );

  // Free running clock of 4 ns period
  initial
  begin
    tb_clk = 1'b0;
    forever
      #CLK_HALF tb_clk = ~tb_clk;
  end

  // Bus tasks, packet driver and compare tasks
  `include "tb_uart_tasks.svh"

  // Reference model keeps only the low size bits of the sent data
  function automatic rx_byte_t expected_rx(input rx_byte_t data, input data_size_t size);
    rx_byte_t mask;
    mask = 8'hFF >> (4'd8 - size);
    return data & mask;
  endfunction

  // Watchdog on the whole run
  always @(posedge tb_clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the test sequence did not finish in %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $fatal(1, "Run stopped by the watchdog");
    end
  end

  // ************************************************
  // Test sequence
  // ************************************************
  initial
  begin
    reset       = 1'b1;
    apb_req     = '0;
    serial_in   = 1'b1;
    seed        = 32'h55a2b030;
    cycle_count = 0;
    repeat (RESET_CYCLES) @(posedge tb_clk);
    @(negedge tb_clk);
    reset = 1'b0;

    // Reset values
    read_flags(got_flags);
    check_flags(got_flags, 3'b000, "flags after reset");
    read_ok(ADDR_RX_DATA, rd_val);
    check_byte(rd_val, 8'hFF, "rx data after reset");
    read_cfg(got_period, got_size);
    check_cfg(got_period, got_size, 14'd10, 4'd8);

    // Configuration round trips with the period split over CR0 and CR1
    write_period(14'd10);
    read_cfg(got_period, got_size);
    check_cfg(got_period, got_size, 14'd10, 4'd8);
    write_period(14'd1000);
    read_cfg(got_period, got_size);
    check_cfg(got_period, got_size, 14'd1000, 4'd8);
    write_ok(ADDR_DATA_CR, 8'd5);
    read_cfg(got_period, got_size);
    check_cfg(got_period, got_size, 14'd1000, 4'd5);
    write_period(TEST_PERIOD);

    // Good packets at full and shortest size
    for (int i = 0; i < 2; i++)
    begin
      test_size = (i == 0) ? 4'd8 : 4'd5;
      write_ok(ADDR_DATA_CR, {4'd0, test_size});
      data_a = $random(seed);
      send_packet(data_a, test_size, 1'b1);
      read_flags(got_flags);
      check_flags(got_flags, 3'b100, "flags after good packet");
      read_ok(ADDR_RX_DATA, rd_val);
      check_byte(rd_val, expected_rx(data_a, test_size), "rx data of good packet");
      read_flags(got_flags);
      check_flags(got_flags, 3'b000, "flags after data read");
    end
    prev_byte = expected_rx(data_a, test_size);

    // Bad stop bit leaves the old byte in the buffer
    write_ok(ADDR_DATA_CR, 8'd8);
    data_a = $random(seed);
    send_packet(data_a, 4'd8, 1'b0);
    read_flags(got_flags);
    check_flags(got_flags, 3'b010, "flags after framing error");
    read_ok(ADDR_RX_DATA, rd_val);
    check_byte(rd_val, prev_byte, "rx data after framing error");
    data_b = $random(seed);
    send_packet(data_b, 4'd8, 1'b1);
    read_flags(got_flags);
    check_flags(got_flags, 3'b100, "flags after recovery packet");
    read_ok(ADDR_RX_DATA, rd_val);
    check_byte(rd_val, data_b, "rx data of recovery packet");
    read_flags(got_flags);
    check_flags(got_flags, 3'b000, "flags after recovery read");

    // Two packets with no read between them
    data_a = $random(seed);
    data_b = $random(seed);
    send_packet(data_a, 4'd8, 1'b1);
    send_packet(data_b, 4'd8, 1'b1);
    read_flags(got_flags);
    check_flags(got_flags, 3'b101, "flags after overrun");
    read_ok(ADDR_RX_DATA, rd_val);
    check_byte(rd_val, data_b, "rx data after overrun");
    read_flags(got_flags);
    check_flags(got_flags, 3'b000, "flags after overrun read");

    // Illegal accesses
    apb_read(3'd5, rd_val, got_err);
    check_err(got_err, 1'b1, "read of address 5");
    apb_read(3'd7, rd_val, got_err);
    check_err(got_err, 1'b1, "read of address 7");
    apb_write(ADDR_RX_DATA, 8'h3C, got_err);
    check_err(got_err, 1'b1, "write to rx data");
    apb_write(ADDR_DATA_CR, 8'd9, got_err);
    check_err(got_err, 1'b1, "data size write of 9");
    read_cfg(got_period, got_size);
    check_cfg(got_period, got_size, TEST_PERIOD, 4'd8);
    read_ok(ADDR_RX_DATA, rd_val);
    check_byte(rd_val, data_b, "rx data after illegal write");

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+testbench
logic/uart_rx_pkg.sv
logic/apb_uart_regs.sv
logic/uart_rx_timer.sv
logic/uart_rx_ctrl.sv
logic/uart_rx_shifter.sv
logic/uart_rx_buffer.sv
logic/apb_uart_rx.sv
testbench/tb_apb_uart_rx.sv
